// File: flist.f
dcache_cfg_pkg.sv
dcache_bus_pkg.sv
line_store.sv
dcache_lookup.sv
dcache_ctrl.sv
dcache_data.sv
dcache_top.sv
tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - dcache_cfg_pkg.sv
  - dcache_bus_pkg.sv
  - line_store.sv
  - dcache_lookup.sv
  - dcache_ctrl.sv
  - dcache_data.sv
  - dcache_top.sv
  - target: test
    files:
      - tb_dcache.sv

// File: tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache import dcache_cfg_pkg::*, dcache_bus_pkg::*; ();

  localparam int N_OPS          = 212;  // 1 + 7 + 2 + 2 + 200
  localparam int TIMEOUT_CYCLES = N_OPS * 120;
  localparam logic [ADDR_W-1:0] LINE_A = 32'h0001_2040;  // tag 0x12, index 1
  localparam logic [ADDR_W-1:0] LINE_B = 32'h0003_4040;  // same index, tag 0x34

  logic     clk = 1'b0;
  logic     rst;
  cpu_req_t cpu_req_i;
  logic     cpu_ready_o;
  word_t    cpu_rdata_o;
  mem_req_t mem_req_o;
  word_t    mem_wdata_o;
  word_t    mem_rdata_i;
  logic     mem_rready_i;
  logic     mem_wready_i;

  word_t             mem_q [bit [28:0]];  // sparse memory, word addressed
  word_t             shadow [bit [28:0]];
  word_t             exp_q [$];
  logic [ADDR_W-1:0] wb_addr_q [$];
  word_t             wb_data_q [$];
  logic [3:0]        stall_pat [1024];
  beat_t             rd_beat = '0;
  beat_t             wr_beat = '0;
  int                rd_total = 0;
  int                cyc = 0;
  int                checks = 0;
  int                errors = 0;
  int                test_base = 0;

  dcache_top dcache_top_inst (
    .clk          (clk),
    .rst          (rst),
    .cpu_req_i    (cpu_req_i),
    .cpu_ready_o  (cpu_ready_o),
    .cpu_rdata_o  (cpu_rdata_o),
    .mem_req_o    (mem_req_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_rdata_i  (mem_rdata_i),
    .mem_rready_i (mem_rready_i),
    .mem_wready_i (mem_wready_i)
  );

  always #50 clk = ~clk;

  function automatic word_t init_word(logic [ADDR_W-1:0] addr);
    logic [31:0] w;
    w = addr >> 3;
    return {w ^ 32'ha5c3_0f69, ~w * 32'h9e37_79b9};
  endfunction

  function automatic word_t mem_read(logic [ADDR_W-1:0] addr);
    if (mem_q.exists(addr[31:3])) begin
      return mem_q[addr[31:3]];
    end
    return init_word(addr);
  endfunction

  // expected read value, applies the byte merge for writes
  function automatic word_t ref_model(logic wr, logic [ADDR_W-1:0] addr, word_t wdata,
                                      strb_t strb);
    word_t cur;
    cur = shadow.exists(addr[31:3]) ? shadow[addr[31:3]] : init_word(addr);
    if (wr) begin
      for (int b = 0; b < WORD_W / 8; b++) begin
        if (strb[b]) begin
          cur[b*8 +: 8] = wdata[b*8 +: 8];
        end
      end
      shadow[addr[31:3]] = cur;
    end
    return cur;
  endfunction

  task automatic check(string name, logic [63:0] got, logic [63:0] exp_val);
    checks++;
    if (got !== exp_val) begin
      errors++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp_val);
    end
  endtask

  task automatic access(logic wr, logic [ADDR_W-1:0] addr, word_t wdata, strb_t strb);
    cpu_req_t req;
    word_t    exp_word;
    exp_word = ref_model(wr, addr, wdata, strb);
    if (!wr) begin
      exp_q.push_back(exp_word);
    end
    req.valid = 1'b1;
    req.write = wr;
    req.addr  = addr;
    req.wdata = wdata;
    req.strb  = strb;
    @(posedge clk);
    cpu_req_i <= req;
    do @(posedge clk); while (!cpu_ready_o);
    cpu_req_i <= '0;
    @(posedge clk);  // let the compare process see the ready cycle
  endtask

  task automatic end_test(string name);
    $display("test %-24s %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  // memory model with random stalls
  always @(posedge clk) begin
    if (mem_req_o.rvalid && mem_rready_i) begin
      rd_beat <= rd_beat + 1'b1;
      rd_total++;
    end
    if (mem_req_o.wvalid && mem_wready_i) begin
      mem_q[{mem_req_o.addr[31:6], wr_beat}] = mem_wdata_o;
      wb_addr_q.push_back(mem_req_o.addr);
      wb_data_q.push_back(mem_wdata_o);
      wr_beat <= wr_beat + 1'b1;
    end
    mem_rready_i <= !rst && (stall_pat[cyc % 1024][1:0] != 2'b00);
    mem_wready_i <= !rst && (stall_pat[cyc % 1024][3:2] != 2'b00);
  end

  always @(negedge clk) begin
    mem_rdata_i <= mem_read({mem_req_o.addr[31:6], rd_beat, 3'b000});  // word for this beat
  end

  // compare read data against the reference queue
  always @(posedge clk) begin
    if (cpu_ready_o && !cpu_req_i.valid) begin
      errors++;
      $display("cpu_ready_o pulsed while no request was pending");
    end else if (cpu_ready_o && !cpu_req_i.write) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("read completed with no expected value queued");
      end else begin
        check("cpu_rdata_o", cpu_rdata_o, exp_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    int                rd_before;
    logic [ADDR_W-1:0] a;
    logic [TAG_W-1:0]  tag;
    idx_t              idx;
    void'($urandom(32'h9aa6));
    for (int i = 0; i < 1024; i++) begin
      stall_pat[i] = 4'($urandom);
    end
    rst          = 1'b1;
    cpu_req_i    = '0;
    mem_rdata_i  = '0;
    mem_rready_i = 1'b0;
    mem_wready_i = 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    rd_before = rd_total;
    access(1'b0, LINE_A + 32'h10, '0, '0);
    check("refill beats", rd_total - rd_before, 8);
    end_test("cold read miss");

    rd_before = rd_total;
    for (int w = 0; w < BEATS; w++) begin
      if (w != 2) begin
        access(1'b0, LINE_A + 32'(w * 8), '0, '0);
      end
    end
    check("refill beats on hits", rd_total - rd_before, 0);
    end_test("read hits same line");

    access(1'b1, LINE_A + 32'h18, 64'h1122_3344_5566_7788, 8'b0101_1010);
    access(1'b0, LINE_A + 32'h18, '0, '0);
    end_test("partial write merge");

    wb_addr_q.delete();
    wb_data_q.delete();
    access(1'b0, LINE_B + 32'h10, '0, '0);  // evicts dirty line A
    check("write-back beats", wb_addr_q.size(), 8);
    if (wb_addr_q.size() == 8) begin
      for (int k = 0; k < BEATS; k++) begin
        check("mem_req_o.addr", wb_addr_q[k], LINE_A);
        check("mem_wdata_o", wb_data_q[k], ref_model(1'b0, LINE_A + 32'(k * 8), '0, '0));
      end
    end
    access(1'b0, LINE_A + 32'h18, '0, '0);
    end_test("dirty eviction");

    for (int i = 0; i < 200; i++) begin
      tag = 20'h00012 + 20'(($urandom % 4) * 32'h22);  // 0x12, 0x34, 0x56, 0x78
      idx = 6'(1 + $urandom % 2);
      a   = {tag, idx, 3'($urandom), 3'b000};
      access(1'($urandom), a, {$urandom, $urandom}, 8'($urandom));
    end
    end_test("random traffic");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_cfg_pkg::*, dcache_bus_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  cpu_req_t cpu_req_i,
  output logic     cpu_ready_o,
  output word_t    cpu_rdata_o,
  output mem_req_t mem_req_o,
  output word_t    mem_wdata_o,
  input  word_t    mem_rdata_i,
  input  logic     mem_rready_i,
  input  logic     mem_wready_i
);

  logic  hit;
  logic  dirty;
  tag_t  victim_tag;
  logic  refill_done;
  logic  hit_write;
  logic  refill_we;
  logic  wb_en;
  beat_t beat;

  dcache_lookup dcache_lookup_inst (
    .clk           (clk),
    .rst           (rst),
    .addr_i        (cpu_req_i.addr),
    .refill_done_i (refill_done),
    .hit_write_i   (hit_write),
    .hit_o         (hit),
    .dirty_o       (dirty),
    .victim_tag_o  (victim_tag)
  );

  dcache_ctrl dcache_ctrl_inst (
    .clk           (clk),
    .rst           (rst),
    .cpu_req_i     (cpu_req_i),
    .hit_i         (hit),
    .dirty_i       (dirty),
    .victim_tag_i  (victim_tag),
    .mem_rready_i  (mem_rready_i),
    .mem_wready_i  (mem_wready_i),
    .mem_req_o     (mem_req_o),
    .cpu_ready_o   (cpu_ready_o),
    .refill_done_o (refill_done),
    .hit_write_o   (hit_write),
    .refill_we_o   (refill_we),
    .wb_en_o       (wb_en),
    .beat_o        (beat)
  );

  dcache_data dcache_data_inst (
    .clk         (clk),
    .rst         (rst),
    .addr_i      (cpu_req_i.addr),
    .wdata_i     (cpu_req_i.wdata),
    .strb_i      (cpu_req_i.strb),
    .mem_rdata_i (mem_rdata_i),
    .beat_i      (beat),
    .refill_we_i (refill_we),
    .wb_en_i     (wb_en),
    .hit_write_i (hit_write),
    .rdata_o     (cpu_rdata_o),
    .wb_data_o   (mem_wdata_o)
  );

endmodule

// File: dcache_data.sv
`timescale 1ns/1ps

module dcache_data import dcache_cfg_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] addr_i,
  input  word_t             wdata_i,
  input  strb_t             strb_i,
  input  word_t             mem_rdata_i,
  input  beat_t             beat_i,
  input  logic              refill_we_i,
  input  logic              wb_en_i,
  input  logic              hit_write_i,
  output word_t             rdata_o,
  output word_t             wb_data_o
);

  idx_t                     line_idx;
  beat_t                    word_sel;
  logic [IDX_W+BEAT_W-1:0]  store_addr;
  word_t                    rd_word;
  word_t                    merged;
  word_t                    wr_word;

  assign line_idx = addr_i[OFF_W +: IDX_W];

  // bursts walk the line, cpu access uses its own word
  assign word_sel   = (refill_we_i || wb_en_i) ? beat_i : addr_i[BYTE_W +: BEAT_W];
  assign store_addr = {line_idx, word_sel};

  always_comb begin
    merged = rd_word;
    for (int b = 0; b < WORD_W / 8; b++) begin
      if (strb_i[b]) begin
        merged[b*8 +: 8] = wdata_i[b*8 +: 8];
      end
    end
  end

  assign wr_word = refill_we_i ? mem_rdata_i : merged;  // refill beats go in whole

  line_store #(
    .DEPTH   (NUM_LINES * BEATS),
    .entry_t (word_t)
  ) data_store_inst (
    .clk     (clk),
    .rst     (rst),
    .we_i    (refill_we_i | hit_write_i),
    .waddr_i (store_addr),
    .raddr_i (store_addr),
    .wdata_i (wr_word),
    .rdata_o (rd_word)
  );

  assign rdata_o   = rd_word;
  assign wb_data_o = rd_word;  // word of the current write beat

endmodule

// File: dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl import dcache_cfg_pkg::*, dcache_bus_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  cpu_req_t cpu_req_i,
  input  logic     hit_i,
  input  logic     dirty_i,
  input  tag_t     victim_tag_i,
  input  logic     mem_rready_i,
  input  logic     mem_wready_i,
  output mem_req_t mem_req_o,
  output logic     cpu_ready_o,
  output logic     refill_done_o,
  output logic     hit_write_o,
  output logic     refill_we_o,
  output logic     wb_en_o,
  output beat_t    beat_o
);

  typedef enum logic [1:0] {
    IDLE,
    SETTLE,
    WRITE_BACK,
    REFILL
  } state_t;

  state_t state_q;
  beat_t  beat_q;
  tag_t   req_tag;
  idx_t   req_idx;
  logic   last_beat;
  logic   r_beat;
  logic   w_beat;

  assign req_tag   = cpu_req_i.addr[ADDR_W-1 -: TAG_W];
  assign req_idx   = cpu_req_i.addr[OFF_W +: IDX_W];
  assign last_beat = (beat_q == beat_t'(BEATS - 1));
  assign r_beat    = (state_q == REFILL) && mem_rready_i;
  assign w_beat    = (state_q == WRITE_BACK) && mem_wready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      beat_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          beat_q <= '0;
          if (cpu_req_i.valid) begin
            if (hit_i) begin
              state_q <= SETTLE;
            end else if (dirty_i) begin
              state_q <= WRITE_BACK;  // evict before refill
            end else begin
              state_q <= REFILL;
            end
          end
        end
        SETTLE: begin
          state_q <= IDLE;  // cpu swaps request here
        end
        WRITE_BACK: begin
          if (w_beat) begin
            beat_q <= beat_q + 1'b1;  // wraps to 0 for refill
            if (last_beat) begin
              state_q <= REFILL;
            end
          end
        end
        REFILL: begin
          if (r_beat) begin
            beat_q <= beat_q + 1'b1;
            if (last_beat) begin
              state_q <= IDLE;  // replay as a hit
            end
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // burst address holds for the whole line
  always_comb begin
    mem_req_o.rvalid = (state_q == REFILL);
    mem_req_o.wvalid = (state_q == WRITE_BACK);
    if (state_q == WRITE_BACK) begin
      mem_req_o.addr = {victim_tag_i, req_idx, {OFF_W{1'b0}}};
    end else begin
      mem_req_o.addr = {req_tag, req_idx, {OFF_W{1'b0}}};
    end
  end

  assign cpu_ready_o   = (state_q == SETTLE);
  assign hit_write_o   = (state_q == SETTLE) && cpu_req_i.write;
  assign refill_we_o   = r_beat;
  assign refill_done_o = r_beat && last_beat;  // tag lands with last word
  assign wb_en_o       = (state_q == WRITE_BACK);
  assign beat_o        = beat_q;

endmodule

// File: dcache_lookup.sv
`timescale 1ns/1ps

module dcache_lookup import dcache_cfg_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic              refill_done_i,
  input  logic              hit_write_i,
  output logic              hit_o,
  output logic              dirty_o,
  output tag_t              victim_tag_o
);

  tag_t       req_tag;
  idx_t       req_idx;
  tag_entry_t rd_entry;
  tag_entry_t wr_entry;

  assign req_tag = addr_i[ADDR_W-1 -: TAG_W];
  assign req_idx = addr_i[OFF_W +: IDX_W];

  // new entry on refill, otherwise only the dirty bit moves
  always_comb begin
    wr_entry = rd_entry;
    if (refill_done_i) begin
      wr_entry.valid = 1'b1;
      wr_entry.dirty = 1'b0;
      wr_entry.tag   = req_tag;
    end else if (hit_write_i) begin
      wr_entry.dirty = 1'b1;
    end
  end

  line_store #(
    .DEPTH   (NUM_LINES),
    .entry_t (tag_entry_t)
  ) tag_store_inst (
    .clk     (clk),
    .rst     (rst),
    .we_i    (refill_done_i | hit_write_i),
    .waddr_i (req_idx),
    .raddr_i (req_idx),
    .wdata_i (wr_entry),
    .rdata_o (rd_entry)
  );

  assign hit_o        = rd_entry.valid && (rd_entry.tag == req_tag);
  assign dirty_o      = rd_entry.valid && rd_entry.dirty;  // victim needs write-back
  assign victim_tag_o = rd_entry.tag;

endmodule

// File: line_store.sv
`timescale 1ns/1ps

module line_store #(
  parameter int  DEPTH   = 64,
  parameter type entry_t = logic [7:0]
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  input  entry_t                   wdata_i,
  output entry_t                   rdata_o
);

  entry_t mem_q [DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem_q[i] <= '0;  // all-zero entry reads as invalid
      end
    end else if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_o = mem_q[raddr_i];  // async read

endmodule

// File: dcache_bus_pkg.sv
package dcache_bus_pkg;

  import dcache_cfg_pkg::*;

  // load/store request from the cpu, held until ready
  typedef struct packed {
    logic              valid;
    logic              write;
    logic [ADDR_W-1:0] addr;
    word_t             wdata;
    strb_t             strb;
  } cpu_req_t;

  // line burst request toward memory
  typedef struct packed {
    logic              rvalid;
    logic              wvalid;
    logic [ADDR_W-1:0] addr;  // always line aligned
  } mem_req_t;

endpackage

// File: dcache_cfg_pkg.sv
package dcache_cfg_pkg;

  // address split is tag | index | offset
  localparam int ADDR_W    = 32;
  localparam int WORD_W    = 64;
  localparam int TAG_W     = 20;
  localparam int IDX_W     = 6;
  localparam int OFF_W     = 6;
  localparam int NUM_LINES = 64;
  localparam int BEATS     = 8;  // words per line
  localparam int BEAT_W    = 3;
  localparam int BYTE_W    = 3;  // byte select bits inside a word

  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [IDX_W-1:0]    idx_t;
  typedef logic [BEAT_W-1:0]   beat_t;
  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [WORD_W/8-1:0] strb_t;  // one enable per byte lane

  typedef struct packed {
    logic valid;
    logic dirty;  // line differs from memory
    tag_t tag;
  } tag_entry_t;

endpackage
